// ==== common/espi_regs_pkg.sv ====
/*
 * eSPI register block shared definitions
 * types, configuration addresses, writable field positions,
 * version ID and status word reset values
 */
package espi_regs_pkg;

    typedef logic [15:0] cfg_addr_t;
    typedef logic [31:0] cfg_data_t;
    typedef logic [15:0] status_t;
    typedef logic [7:0]  err_t;        // one bit per error cause
    typedef logic [1:0]  io_mode_t;
    typedef logic [2:0]  size_code_t;  // encoded payload / readreq / freq

    // ------------------------------------------------------------------
    // configuration space addresses
    // ------------------------------------------------------------------
    localparam cfg_addr_t DEVICE_ID_ADDR       = 16'h0004;
    localparam cfg_addr_t GENERAL_CONFIG_ADDR  = 16'h0008;
    localparam cfg_addr_t CHANNEL0_CONFIG_ADDR = 16'h0010;
    localparam cfg_addr_t CHANNEL1_CONFIG_ADDR = 16'h0020;

    localparam logic [7:0] VERSION_ID = 8'h01;

    localparam status_t STATUS_DEFAULT_PC    = 16'h030F;  // peripheral channel supported
    localparam status_t STATUS_DEFAULT_NO_PC = 16'h030C;

    // ------------------------------------------------------------------
    // general register fields
    // ------------------------------------------------------------------
    localparam int GEN_CRC_EN_BIT     = 31;
    localparam int GEN_RESP_MOD_BIT   = 30;
    localparam int GEN_ALERT_MODE_BIT = 28;
    localparam int GEN_IO_MODE_MSB    = 27;
    localparam int GEN_IO_MODE_LSB    = 26;
    localparam int GEN_FREQ_MSB       = 22;
    localparam int GEN_FREQ_LSB       = 20;
    localparam int GEN_WAIT_MSB       = 15;
    localparam int GEN_WAIT_LSB       = 12;

    // channel 0, peripheral
    localparam int CH0_READREQ_MSB    = 14;
    localparam int CH0_READREQ_LSB    = 12;
    localparam int CH0_PAYLOAD_MSB    = 10;
    localparam int CH0_PAYLOAD_LSB    = 8;
    localparam int CH0_BUS_MASTER_BIT = 2;
    localparam int CH0_EN_BIT         = 0;

    // channel 1, virtual wire
    localparam int CH1_VW_COUNT_MSB   = 21;
    localparam int CH1_VW_COUNT_LSB   = 16;
    localparam int CH1_EN_BIT         = 0;

endpackage

// ==== rtl/config/espi_config_regs.sv ====
/*
 * eSPI configuration registers
 * device ID, general, channel 0 and channel 1 words written by
 * SET_CONFIGURATION and read back by GET_CONFIGURATION, plus the
 * one-cycle peripheral channel reset pulse on disable
 */
module espi_config_regs #(
    parameter espi_regs_pkg::io_mode_t   IO_MODE_RANGE             = 2'b11,
    parameter bit                        OPEN_DRAIN_ALERT_EN       = 1'b0,
    parameter espi_regs_pkg::size_code_t MAX_FREQ_RANGE            = 3'b000,
    parameter logic [7:0]                CHANNEL_SUPPORT           = 8'h01,
    parameter espi_regs_pkg::size_code_t MAX_PC_PAYLOAD_SIZE_RANGE = 3'b001,
    parameter logic [5:0]                MAX_VW_COUNT_SUPPORTED    = 6'h0F
) (
    input  logic                       clk,
    input  logic                       ip_reset_n,
    input  logic                       pltrst_n,
    input  logic                       detect_reset,
    input  logic                       detect_setconfig,
    input  logic                       detect_getconfig,
    input  logic                       stop_det,
    input  espi_regs_pkg::cfg_addr_t   config_reg_addr,
    input  espi_regs_pkg::cfg_data_t   config_reg_datain,
    input  logic                       pc_channel_ready,
    input  logic                       vw_channel_ready,
    output espi_regs_pkg::cfg_data_t   config_reg_dataout,
    output logic                       crc_en,
    output logic                       resp_mod_en,
    output logic                       alert_mode,
    output espi_regs_pkg::io_mode_t    io_mode,
    output espi_regs_pkg::size_code_t  freq_value,
    output logic [3:0]                 max_wait_state,
    output espi_regs_pkg::size_code_t  max_pc_payload_size,
    output espi_regs_pkg::size_code_t  max_pc_readreq_size,
    output logic                       bus_master_en,
    output logic                       pc_channel_en,
    output logic [5:0]                 max_vw_count,
    output logic                       vw_channel_en,
    output logic                       pc_channel_reset
);
    import espi_regs_pkg::*;

    logic      reset_cmd, wr_general, wr_ch0, wr_ch1;
    logic      ch0_reset_n;
    logic      pc_channel_en_d;
    cfg_data_t device_id_word, general_word, ch0_word, ch1_word, read_word;

    assign reset_cmd   = detect_reset && stop_det;
    assign wr_general  = stop_det && detect_setconfig && (config_reg_addr == GENERAL_CONFIG_ADDR);
    assign wr_ch0      = stop_det && detect_setconfig && (config_reg_addr == CHANNEL0_CONFIG_ADDR);
    assign wr_ch1      = stop_det && detect_setconfig && (config_reg_addr == CHANNEL1_CONFIG_ADDR);
    assign ch0_reset_n = ip_reset_n && pltrst_n;  // platform reset hits channel 0 only

    // ------------------------------------------------------------------
    // writable fields
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            crc_en         <= 1'b0;
            resp_mod_en    <= 1'b0;
            alert_mode     <= 1'b0;
            io_mode        <= '0;
            freq_value     <= '0;
            max_wait_state <= '0;
        end else if (reset_cmd) begin
            // in-band reset command
            crc_en         <= 1'b0;
            resp_mod_en    <= 1'b0;
            alert_mode     <= 1'b0;
            io_mode        <= '0;
            freq_value     <= '0;
            max_wait_state <= '0;
        end else if (wr_general) begin
            crc_en         <= config_reg_datain[GEN_CRC_EN_BIT];
            resp_mod_en    <= config_reg_datain[GEN_RESP_MOD_BIT];
            alert_mode     <= config_reg_datain[GEN_ALERT_MODE_BIT];
            io_mode        <= config_reg_datain[GEN_IO_MODE_MSB:GEN_IO_MODE_LSB];
            freq_value     <= config_reg_datain[GEN_FREQ_MSB:GEN_FREQ_LSB];
            max_wait_state <= config_reg_datain[GEN_WAIT_MSB:GEN_WAIT_LSB];
        end
    end

    always_ff @(posedge clk or negedge ch0_reset_n) begin
        if (!ch0_reset_n) begin
            max_pc_readreq_size <= 3'b001;  // 64 bytes
            max_pc_payload_size <= 3'b001;
            bus_master_en       <= 1'b0;
            pc_channel_en       <= 1'b1;
        end else if (wr_ch0) begin
            max_pc_readreq_size <= config_reg_datain[CH0_READREQ_MSB:CH0_READREQ_LSB];
            max_pc_payload_size <= config_reg_datain[CH0_PAYLOAD_MSB:CH0_PAYLOAD_LSB];
            bus_master_en       <= config_reg_datain[CH0_BUS_MASTER_BIT];
            pc_channel_en       <= config_reg_datain[CH0_EN_BIT];
        end
    end

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            max_vw_count  <= '0;
            vw_channel_en <= 1'b0;
        end else if (wr_ch1) begin
            max_vw_count  <= config_reg_datain[CH1_VW_COUNT_MSB:CH1_VW_COUNT_LSB];
            vw_channel_en <= config_reg_datain[CH1_EN_BIT];
        end
    end

    // ------------------------------------------------------------------
    // read words built from fields and capability parameters
    // ------------------------------------------------------------------
    assign device_id_word = {24'h0, VERSION_ID};
    assign general_word   = {crc_en, resp_mod_en, 1'b0, alert_mode, io_mode, IO_MODE_RANGE,
                             1'b0,                // open-drain alert select held at push-pull
                             freq_value, OPEN_DRAIN_ALERT_EN, MAX_FREQ_RANGE,
                             max_wait_state, 4'h0, CHANNEL_SUPPORT};
    assign ch0_word       = {17'h0, max_pc_readreq_size, 1'b0, max_pc_payload_size, 1'b0,
                             MAX_PC_PAYLOAD_SIZE_RANGE, 1'b0, bus_master_en,
                             pc_channel_ready, pc_channel_en};
    assign ch1_word       = {10'h0, max_vw_count, 2'b00, MAX_VW_COUNT_SUPPORTED, 6'h0,
                             vw_channel_ready, vw_channel_en};

    always_comb begin
        read_word = '0;  // unknown address reads zero
        if (detect_getconfig) begin
            case (config_reg_addr)
                DEVICE_ID_ADDR:       read_word = device_id_word;
                GENERAL_CONFIG_ADDR:  read_word = general_word;
                CHANNEL0_CONFIG_ADDR: read_word = ch0_word;
                CHANNEL1_CONFIG_ADDR: read_word = ch1_word;
                default:              read_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            config_reg_dataout <= '0;
            pc_channel_en_d    <= 1'b0;
            pc_channel_reset   <= 1'b0;
        end else begin
            config_reg_dataout <= read_word;
            pc_channel_en_d    <= pc_channel_en;
            pc_channel_reset   <= !pc_channel_en && pc_channel_en_d;  // falling edge of enable
        end
    end

    a_pc_reset_single: assert property (
        @(posedge clk) disable iff (!ip_reset_n) pc_channel_reset |=> !pc_channel_reset);

endmodule

// ==== rtl/espi_status_tracker.sv ====
/*
 * eSPI status word tracker
 * assembles the 16-bit status word and requests a status update
 * when it changes inside an alert or chip-select window
 */
module espi_status_tracker #(
    parameter logic [7:0] CHANNEL_SUPPORT = 8'h01
) (
    input  logic                    clk,
    input  logic                    ip_reset_n,
    input  logic                    start_det,
    input  logic                    stop_det,
    input  logic                    tx_gen_status,
    input  logic                    espi_cs_n_nxt2,
    input  logic                    vwire_avail,
    input  logic                    np_free,
    input  logic                    pc_free,
    input  logic                    pc_txfifo_avail,
    input  logic                    np_txfifo_avail,
    output espi_regs_pkg::status_t  status_reg_dataout,
    output logic                    update_status_reg
);
    import espi_regs_pkg::*;

    localparam status_t STATUS_RESET = CHANNEL_SUPPORT[0] ? STATUS_DEFAULT_PC
                                                          : STATUS_DEFAULT_NO_PC;

    status_t status_field, status_reg, status_prev;
    logic    alert_phase;

    assign status_field = {6'h00,
                           2'b11,            // flash channel free bits
                           1'b0,             // oob_avail
                           vwire_avail,
                           np_txfifo_avail,
                           pc_txfifo_avail,
                           1'b1,             // oob_free
                           1'b1,             // vwire_free
                           np_free,
                           pc_free};

    assign status_reg_dataout = status_reg;

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            status_reg  <= STATUS_RESET;
            status_prev <= STATUS_RESET;
        end else begin
            status_reg  <= status_field;
            status_prev <= status_reg;
        end
    end

    // alert phase opens with a generated status and closes at stop
    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            alert_phase <= 1'b0;
        end else if (tx_gen_status) begin
            alert_phase <= 1'b1;
        end else if (stop_det) begin
            alert_phase <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            update_status_reg <= 1'b0;
        end else if ((tx_gen_status || alert_phase || espi_cs_n_nxt2) &&
                     (status_prev != status_reg)) begin
            update_status_reg <= 1'b1;
        end else if (start_det) begin
            update_status_reg <= 1'b0;  // held until the next transaction starts
        end
    end

endmodule

// ==== rtl/espi_host_regs.sv ====
/*
 * eSPI host-side registers
 * TX FIFO available control bits, sticky write-one-to-clear error
 * register, RX available mirror and the registered interrupt
 */
module espi_host_regs (
    input  logic                  clk,
    input  logic                  ip_reset_n,
    input  logic                  write_control_reg,
    input  logic                  write_error_reg,
    input  logic [7:0]            avmm_writedata,
    input  logic                  get_pc_txfifo,
    input  logic                  get_np_txfifo,
    input  logic                  pc_rxfifo_avail,
    input  logic                  np_rxfifo_avail,
    input  logic                  invalid_cmd,
    input  logic                  invalid_cycletype,
    input  logic                  crc_error,
    input  logic                  invalid_cs_deassertion,
    input  logic                  invalid_putfifo,
    input  logic                  invalid_getfifo,
    input  logic                  malform_pc_packet,
    input  logic                  malform_vw_packet,
    output logic                  pc_txfifo_avail,
    output logic                  np_txfifo_avail,
    output logic [1:0]            avalon_status_reg,
    output espi_regs_pkg::err_t   error_reg,
    output logic                  interrupt
);
    import espi_regs_pkg::*;

    err_t       err_cause;
    logic [1:0] rx_avail;

    assign err_cause = {malform_vw_packet, malform_pc_packet, invalid_getfifo, invalid_putfifo,
                        invalid_cs_deassertion, crc_error, invalid_cycletype, invalid_cmd};
    assign rx_avail  = {np_rxfifo_avail, pc_rxfifo_avail};

    // ------------------------------------------------------------------
    // control bits, host sets and the transaction layer drains
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            pc_txfifo_avail <= 1'b0;
            np_txfifo_avail <= 1'b0;
        end else begin
            if (write_control_reg && avmm_writedata[0]) begin
                pc_txfifo_avail <= 1'b1;
            end else if (get_pc_txfifo) begin
                pc_txfifo_avail <= 1'b0;
            end
            if (write_control_reg && avmm_writedata[1]) begin
                np_txfifo_avail <= 1'b1;
            end else if (get_np_txfifo) begin
                np_txfifo_avail <= 1'b0;
            end
        end
    end

    // sticky errors, a new cause beats a clear in the same cycle
    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            error_reg <= '0;
        end else begin
            for (int i = 0; i < $bits(err_t); i++) begin
                if (err_cause[i]) begin
                    error_reg[i] <= 1'b1;
                end else if (write_error_reg && avmm_writedata[i]) begin
                    error_reg[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            avalon_status_reg <= '0;
            interrupt         <= 1'b0;
        end else begin
            avalon_status_reg <= rx_avail;
            interrupt         <= (avalon_status_reg != rx_avail) || (|error_reg);
        end
    end

    a_err_irq: assert property (
        @(posedge clk) disable iff (!ip_reset_n) (|error_reg) |=> interrupt);

endmodule

// ==== rtl/espi_register_top.sv ====
/*
 * eSPI register block top level
 * joins the configuration, status and host register blocks
 */
module espi_register_top #(
    parameter espi_regs_pkg::io_mode_t   IO_MODE_RANGE             = 2'b11,
    parameter bit                        OPEN_DRAIN_ALERT_EN       = 1'b0,
    parameter espi_regs_pkg::size_code_t MAX_FREQ_RANGE            = 3'b000,
    parameter logic [7:0]                CHANNEL_SUPPORT           = 8'h01,
    parameter espi_regs_pkg::size_code_t MAX_PC_PAYLOAD_SIZE_RANGE = 3'b001,
    parameter logic [5:0]                MAX_VW_COUNT_SUPPORTED    = 6'h0F
) (
    input  logic                       clk,
    input  logic                       ip_reset_n,
    input  logic                       pltrst_n,
    input  logic                       detect_reset,
    input  logic                       detect_setconfig,
    input  logic                       detect_getconfig,
    input  logic                       stop_det,
    input  logic                       start_det,
    input  logic                       tx_gen_status,
    input  logic                       espi_cs_n_nxt2,
    input  espi_regs_pkg::cfg_addr_t   config_reg_addr,
    input  espi_regs_pkg::cfg_data_t   config_reg_datain,
    input  logic                       vwire_avail,
    input  logic                       np_free,
    input  logic                       pc_free,
    input  logic                       pc_rxfifo_avail,
    input  logic                       np_rxfifo_avail,
    input  logic                       get_pc_txfifo,
    input  logic                       get_np_txfifo,
    input  logic                       pc_channel_ready,
    input  logic                       vw_channel_ready,
    input  logic                       write_control_reg,
    input  logic                       write_error_reg,
    input  logic [7:0]                 avmm_writedata,
    input  logic                       invalid_cmd,
    input  logic                       invalid_cycletype,
    input  logic                       crc_error,
    input  logic                       invalid_cs_deassertion,
    input  logic                       invalid_putfifo,
    input  logic                       invalid_getfifo,
    input  logic                       malform_pc_packet,
    input  logic                       malform_vw_packet,
    output espi_regs_pkg::cfg_data_t   config_reg_dataout,
    output espi_regs_pkg::status_t     status_reg_dataout,
    output logic                       update_status_reg,
    output logic                       crc_en,
    output logic                       resp_mod_en,
    output logic                       alert_mode,
    output espi_regs_pkg::io_mode_t    io_mode,
    output espi_regs_pkg::size_code_t  freq_value,
    output logic [3:0]                 max_wait_state,
    output espi_regs_pkg::size_code_t  max_pc_payload_size,
    output espi_regs_pkg::size_code_t  max_pc_readreq_size,
    output logic                       bus_master_en,
    output logic                       pc_channel_en,
    output logic [5:0]                 max_vw_count,
    output logic                       vw_channel_en,
    output logic                       pc_channel_reset,
    output logic                       pc_txfifo_avail,
    output logic                       np_txfifo_avail,
    output logic [1:0]                 avalon_status_reg,
    output espi_regs_pkg::err_t        error_reg,
    output logic                       interrupt
);

    espi_config_regs #(
        .IO_MODE_RANGE             (IO_MODE_RANGE),
        .OPEN_DRAIN_ALERT_EN       (OPEN_DRAIN_ALERT_EN),
        .MAX_FREQ_RANGE            (MAX_FREQ_RANGE),
        .CHANNEL_SUPPORT           (CHANNEL_SUPPORT),
        .MAX_PC_PAYLOAD_SIZE_RANGE (MAX_PC_PAYLOAD_SIZE_RANGE),
        .MAX_VW_COUNT_SUPPORTED    (MAX_VW_COUNT_SUPPORTED)
    ) u_config_regs (.*);

    // txfifo avail bits feed both the host outputs and the status word
    espi_status_tracker #(
        .CHANNEL_SUPPORT (CHANNEL_SUPPORT)
    ) u_status_tracker (.*);

    espi_host_regs u_host_regs (.*);

endmodule

// ==== tests/tb_espi_register.sv ====
/*
 * eSPI register block testbench
 * random stimulus from an LFSR, a reference model of the register
 * rules and concurrent assertions comparing every output
 */
module tb_espi_register;
    timeunit 1ns;
    timeprecision 1ps;
    import espi_regs_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_CYCLES = 4000;
    localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + 8 + RANDOM_CYCLES);

    logic clk, ip_reset_n, pltrst_n, detect_reset, detect_setconfig, detect_getconfig;
    logic stop_det, start_det, tx_gen_status, espi_cs_n_nxt2;
    cfg_addr_t config_reg_addr;
    cfg_data_t config_reg_datain, config_reg_dataout;
    logic vwire_avail, np_free, pc_free, pc_rxfifo_avail, np_rxfifo_avail;
    logic get_pc_txfifo, get_np_txfifo, pc_channel_ready, vw_channel_ready;
    logic write_control_reg, write_error_reg;
    logic [7:0] avmm_writedata;
    err_t err_in, error_reg;
    status_t status_reg_dataout;
    logic update_status_reg, crc_en, resp_mod_en, alert_mode, bus_master_en, pc_channel_en;
    io_mode_t io_mode;
    size_code_t freq_value, max_pc_payload_size, max_pc_readreq_size;
    logic [3:0] max_wait_state;
    logic [5:0] max_vw_count;
    logic vw_channel_en, pc_channel_reset, pc_txfifo_avail, np_txfifo_avail, interrupt;
    logic [1:0] avalon_status_reg;
    logic [31:0] lfsr = 32'h92a6a3c3;
    int cycles = 0;

    cfg_addr_t addr_list [4] = '{DEVICE_ID_ADDR, GENERAL_CONFIG_ADDR,
                                 CHANNEL0_CONFIG_ADDR, CHANNEL1_CONFIG_ADDR};

    espi_register_top u_espi_register_top (
        .invalid_cmd(err_in[0]), .invalid_cycletype(err_in[1]), .crc_error(err_in[2]),
        .invalid_cs_deassertion(err_in[3]), .invalid_putfifo(err_in[4]),
        .invalid_getfifo(err_in[5]), .malform_pc_packet(err_in[6]),
        .malform_vw_packet(err_in[7]), .*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // reference model of the register rules
    // ------------------------------------------------------------------
    logic m_crc, m_resp, m_alert, m_bm, m_pc_en, m_vw_en, m_en_d, m_pcr;
    io_mode_t m_io;
    size_code_t m_freq, m_rdreq, m_payload;
    logic [3:0] m_wait;
    logic [5:0] m_vwcnt;
    cfg_data_t m_dout;
    status_t m_status, m_prev, m_field;
    logic m_alert_ph, m_upd, m_pc_tx, m_np_tx, m_irq;
    logic [1:0] m_avs;
    err_t m_err;
    logic wr_q, m_ch0_rst_n;

    assign wr_q        = stop_det && detect_setconfig;
    assign m_ch0_rst_n = ip_reset_n && pltrst_n;
    assign m_field     = {6'h0, 2'b11, 1'b0, vwire_avail, m_np_tx, m_pc_tx, 2'b11,
                          np_free, pc_free};

    function automatic cfg_data_t expected_word(input cfg_addr_t a);
        case (a)
            DEVICE_ID_ADDR:       return {24'h0, VERSION_ID};
            GENERAL_CONFIG_ADDR:  return {m_crc, m_resp, 1'b0, m_alert, m_io, 2'b11, 1'b0,
                                          m_freq, 1'b0, 3'b000, m_wait, 4'h0, 8'h01};
            CHANNEL0_CONFIG_ADDR: return {17'h0, m_rdreq, 1'b0, m_payload, 1'b0, 3'b001,
                                          1'b0, m_bm, pc_channel_ready, m_pc_en};
            CHANNEL1_CONFIG_ADDR: return {10'h0, m_vwcnt, 2'b00, 6'h0F, 6'h0,
                                          vw_channel_ready, m_vw_en};
            default:              return '0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n || (detect_reset && stop_det)) begin
            {m_crc, m_resp, m_alert, m_io, m_freq, m_wait} <= '0;
        end else if (wr_q && config_reg_addr == GENERAL_CONFIG_ADDR) begin
            m_crc   <= config_reg_datain[GEN_CRC_EN_BIT];
            m_resp  <= config_reg_datain[GEN_RESP_MOD_BIT];
            m_alert <= config_reg_datain[GEN_ALERT_MODE_BIT];
            m_io    <= config_reg_datain[GEN_IO_MODE_MSB:GEN_IO_MODE_LSB];
            m_freq  <= config_reg_datain[GEN_FREQ_MSB:GEN_FREQ_LSB];
            m_wait  <= config_reg_datain[GEN_WAIT_MSB:GEN_WAIT_LSB];
        end
    end

    always_ff @(posedge clk or negedge m_ch0_rst_n) begin
        if (!m_ch0_rst_n) begin
            {m_rdreq, m_payload, m_bm, m_pc_en} <= {3'b001, 3'b001, 1'b0, 1'b1};
        end else if (wr_q && config_reg_addr == CHANNEL0_CONFIG_ADDR) begin
            m_rdreq   <= config_reg_datain[CH0_READREQ_MSB:CH0_READREQ_LSB];
            m_payload <= config_reg_datain[CH0_PAYLOAD_MSB:CH0_PAYLOAD_LSB];
            m_bm      <= config_reg_datain[CH0_BUS_MASTER_BIT];
            m_pc_en   <= config_reg_datain[CH0_EN_BIT];
        end
    end

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            {m_vwcnt, m_vw_en, m_dout, m_en_d, m_pcr} <= '0;
            {m_status, m_prev} <= {STATUS_DEFAULT_PC, STATUS_DEFAULT_PC};
            {m_alert_ph, m_upd, m_pc_tx, m_np_tx, m_irq, m_avs, m_err} <= '0;
        end else begin
            if (wr_q && config_reg_addr == CHANNEL1_CONFIG_ADDR) begin
                m_vwcnt <= config_reg_datain[CH1_VW_COUNT_MSB:CH1_VW_COUNT_LSB];
                m_vw_en <= config_reg_datain[CH1_EN_BIT];
            end
            m_dout <= detect_getconfig ? expected_word(config_reg_addr) : '0;
            m_en_d <= m_pc_en;
            m_pcr  <= m_en_d && !m_pc_en;
            m_status <= m_field;
            m_prev   <= m_status;
            if (tx_gen_status) m_alert_ph <= 1'b1;
            else if (stop_det) m_alert_ph <= 1'b0;
            if ((tx_gen_status || m_alert_ph || espi_cs_n_nxt2) && m_prev != m_status)
                m_upd <= 1'b1;
            else if (start_det)
                m_upd <= 1'b0;
            if (write_control_reg && avmm_writedata[0]) m_pc_tx <= 1'b1;
            else if (get_pc_txfifo) m_pc_tx <= 1'b0;
            if (write_control_reg && avmm_writedata[1]) m_np_tx <= 1'b1;
            else if (get_np_txfifo) m_np_tx <= 1'b0;
            // set wins over a write-one clear
            m_err <= err_in | (m_err & ~(write_error_reg ? avmm_writedata : 8'h00));
            m_avs <= {np_rxfifo_avail, pc_rxfifo_avail};
            m_irq <= (m_avs != {np_rxfifo_avail, pc_rxfifo_avail}) || (m_err != '0);
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail %s got %h expected %h", name, got, exp);
        $display("TB FAILED");
        $fatal(1);
    endtask

    a_dout: assert property (@(posedge clk) disable iff (!ip_reset_n) config_reg_dataout == m_dout)
        else mismatch("config_reg_dataout", $sampled(config_reg_dataout), $sampled(m_dout));
    a_gen: assert property (@(posedge clk) disable iff (!ip_reset_n)
        {crc_en, resp_mod_en, alert_mode, io_mode, freq_value, max_wait_state} ==
        {m_crc, m_resp, m_alert, m_io, m_freq, m_wait})
        else mismatch("general fields",
            32'($sampled({crc_en, resp_mod_en, alert_mode, io_mode, freq_value, max_wait_state})),
            32'($sampled({m_crc, m_resp, m_alert, m_io, m_freq, m_wait})));
    a_ch0: assert property (@(posedge clk) disable iff (!ip_reset_n)
        {max_pc_readreq_size, max_pc_payload_size, bus_master_en, pc_channel_en} ==
        {m_rdreq, m_payload, m_bm, m_pc_en})
        else mismatch("channel 0 fields",
            32'($sampled({max_pc_readreq_size, max_pc_payload_size, bus_master_en, pc_channel_en})),
            32'($sampled({m_rdreq, m_payload, m_bm, m_pc_en})));
    a_ch1: assert property (@(posedge clk) disable iff (!ip_reset_n)
        {max_vw_count, vw_channel_en} == {m_vwcnt, m_vw_en})
        else mismatch("channel 1 fields", 32'($sampled({max_vw_count, vw_channel_en})),
            32'($sampled({m_vwcnt, m_vw_en})));
    a_pcr: assert property (@(posedge clk) disable iff (!ip_reset_n) pc_channel_reset == m_pcr)
        else mismatch("pc_channel_reset", 32'($sampled(pc_channel_reset)), 32'($sampled(m_pcr)));
    a_status: assert property (@(posedge clk) disable iff (!ip_reset_n)
        status_reg_dataout == m_status)
        else mismatch("status_reg_dataout", 32'($sampled(status_reg_dataout)),
            32'($sampled(m_status)));
    a_upd: assert property (@(posedge clk) disable iff (!ip_reset_n) update_status_reg == m_upd)
        else mismatch("update_status_reg", 32'($sampled(update_status_reg)), 32'($sampled(m_upd)));
    a_tx: assert property (@(posedge clk) disable iff (!ip_reset_n)
        {np_txfifo_avail, pc_txfifo_avail} == {m_np_tx, m_pc_tx})
        else mismatch("txfifo_avail", 32'($sampled({np_txfifo_avail, pc_txfifo_avail})),
            32'($sampled({m_np_tx, m_pc_tx})));
    a_avs: assert property (@(posedge clk) disable iff (!ip_reset_n) avalon_status_reg == m_avs)
        else mismatch("avalon_status_reg", 32'($sampled(avalon_status_reg)), 32'($sampled(m_avs)));
    a_err: assert property (@(posedge clk) disable iff (!ip_reset_n) error_reg == m_err)
        else mismatch("error_reg", 32'($sampled(error_reg)), 32'($sampled(m_err)));
    a_irq: assert property (@(posedge clk) disable iff (!ip_reset_n) interrupt == m_irq)
        else mismatch("interrupt", 32'($sampled(interrupt)), 32'($sampled(m_irq)));

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic chance(input int n);  // true with odds 1 in 2**n
        return next_bits(n) == 32'd0;
    endfunction

    task automatic drive_cycle();
        logic [31:0] r;
        @(posedge clk);
        r = next_bits(3);
        case (r[2:0])
            3'd0, 3'd4: config_reg_addr <= GENERAL_CONFIG_ADDR;
            3'd1, 3'd5: config_reg_addr <= CHANNEL0_CONFIG_ADDR;
            3'd2:       config_reg_addr <= CHANNEL1_CONFIG_ADDR;
            3'd3:       config_reg_addr <= DEVICE_ID_ADDR;
            default:    config_reg_addr <= 16'h0040;  // unmapped
        endcase
        config_reg_datain <= next_bits(32);
        stop_det          <= chance(2);
        detect_setconfig  <= chance(1);
        detect_getconfig  <= chance(1);
        detect_reset      <= chance(4);
        pltrst_n          <= !chance(6);
        start_det         <= chance(3);
        tx_gen_status     <= chance(5);
        if (chance(3)) espi_cs_n_nxt2 <= !espi_cs_n_nxt2;
        if (chance(3)) vwire_avail <= !vwire_avail;
        if (chance(4)) np_free <= !np_free;
        if (chance(4)) pc_free <= !pc_free;
        if (chance(4)) pc_rxfifo_avail <= !pc_rxfifo_avail;
        if (chance(4)) np_rxfifo_avail <= !np_rxfifo_avail;
        if (chance(4)) pc_channel_ready <= !pc_channel_ready;
        if (chance(4)) vw_channel_ready <= !vw_channel_ready;
        get_pc_txfifo     <= chance(3);
        get_np_txfifo     <= chance(3);
        write_control_reg <= chance(3);
        write_error_reg   <= chance(2);
        r = next_bits(8);
        avmm_writedata    <= r[7:0];
        for (int i = 0; i < 8; i++) err_in[i] <= chance(5);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles", cycles);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        {ip_reset_n, detect_reset, detect_setconfig, detect_getconfig} = '0;
        {stop_det, start_det, tx_gen_status, espi_cs_n_nxt2} = '0;
        {vwire_avail, np_free, pc_free, pc_rxfifo_avail, np_rxfifo_avail} = '0;
        {get_pc_txfifo, get_np_txfifo, pc_channel_ready, vw_channel_ready} = '0;
        {write_control_reg, write_error_reg, avmm_writedata, err_in} = '0;
        pltrst_n          = 1'b1;
        config_reg_addr   = '0;
        config_reg_datain = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        ip_reset_n <= 1'b1;
        // read back every reset word first
        foreach (addr_list[i]) begin
            @(posedge clk);
            detect_getconfig <= 1'b1;
            config_reg_addr  <= addr_list[i];
        end
        @(posedge clk);
        detect_getconfig <= 1'b0;
        repeat (RANDOM_CYCLES) drive_cycle();
        repeat (4) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== espi_regs.f ====
common/espi_regs_pkg.sv
rtl/config/espi_config_regs.sv
rtl/espi_status_tracker.sv
rtl/espi_host_regs.sv
rtl/espi_register_top.sv
tests/tb_espi_register.sv

// ==== Makefile ====
SRCS := $(shell cat espi_regs.f)

.PHONY: all run clean

all: obj_dir/Vtb_espi_register

obj_dir/Vtb_espi_register: $(SRCS) espi_regs.f
	verilator --binary --assert -f espi_regs.f --top-module tb_espi_register \
		-o Vtb_espi_register

run: obj_dir/Vtb_espi_register
	@out="$$(./obj_dir/Vtb_espi_register)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
